/* riscv_pkg.sv */
// Shared widths, instruction fields and control encodings for the RV64I subset core
`default_nettype none

package riscv_pkg;

   // Data and instruction widths
   typedef logic [63:0] word_t;
   typedef logic [31:0] instr_t;
   typedef logic [4:0]  reg_addr_t;
   typedef logic [3:0]  alu_ctrl_t;
   typedef logic [1:0]  alu_op_t;
   typedef logic [1:0]  fwd_sel_t;

   // Instruction field positions
   localparam int RD_LSB     = 7;
   localparam int FUNCT3_LSB = 12;
   localparam int RS1_LSB    = 15;
   localparam int RS2_LSB    = 20;
   localparam int FUNCT7_LSB = 25;

   // Opcodes of the supported subset
   localparam logic [6:0] OPC_RTYPE  = 7'b0110011;
   localparam logic [6:0] OPC_ITYPE  = 7'b0010011;
   localparam logic [6:0] OPC_LOAD   = 7'b0000011;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;
   localparam logic [6:0] OPC_BRANCH = 7'b1100011;

   localparam logic [6:0] FUNCT7_SUB = 7'b0100000;

   localparam logic [2:0] F3_ADD_SUB = 3'b000;
   localparam logic [2:0] F3_OR      = 3'b110;
   localparam logic [2:0] F3_AND     = 3'b111;

   // Main control to ALU control
   localparam alu_op_t ALUOP_ADD   = 2'b00;
   localparam alu_op_t ALUOP_SUB   = 2'b01;
   localparam alu_op_t ALUOP_FUNCT = 2'b10;

   localparam alu_ctrl_t ALU_AND = 4'b0000;
   localparam alu_ctrl_t ALU_OR  = 4'b0001;
   localparam alu_ctrl_t ALU_ADD = 4'b0010;
   localparam alu_ctrl_t ALU_SUB = 4'b0110;

   // Operand sources for forwarding
   localparam fwd_sel_t FWD_NONE   = 2'b00;
   localparam fwd_sel_t FWD_MEM_WB = 2'b01;
   localparam fwd_sel_t FWD_EX_MEM = 2'b10;

endpackage

`default_nettype wire

/* pipe_if.sv */
// Decode/execute and execute/memory pipeline register bundles
`default_nettype none

interface id_ex_if;
   import riscv_pkg::*;

   // Control bits
   logic      alu_src;
   alu_op_t   alu_op;
   logic      mem_read;
   logic      mem_write;
   logic      mem_2_reg;
   logic      reg_write;
   // Operands and fields
   reg_addr_t rs1;
   reg_addr_t rs2;
   reg_addr_t rd;
   word_t     rdata_1;
   word_t     rdata_2;
   word_t     imm;
   logic [2:0] funct3;
   logic [6:0] funct7;

   modport producer (output alu_src, alu_op, mem_read, mem_write, mem_2_reg, reg_write,
                     rs1, rs2, rd, rdata_1, rdata_2, imm, funct3, funct7);
   modport consumer (input alu_src, alu_op, mem_read, mem_write, mem_2_reg, reg_write,
                     rs1, rs2, rd, rdata_1, rdata_2, imm, funct3, funct7);
endinterface

interface ex_mem_if;
   import riscv_pkg::*;

   word_t     alu_out;
   word_t     store_data;
   reg_addr_t rd;
   logic      reg_write;
   logic      mem_read;
   logic      mem_write;
   logic      mem_2_reg;

   modport producer (output alu_out, store_data, rd, reg_write, mem_read, mem_write, mem_2_reg);
   modport consumer (input alu_out, store_data, rd, reg_write, mem_read, mem_write, mem_2_reg);
   // Hazard and forwarding view
   modport peek (input rd, reg_write, mem_read, alu_out);
endinterface

`default_nettype wire

/* fetch_stage.sv */
// Fetch stage with program counter, loadable instruction memory and fetch/decode register
`default_nettype none

module fetch_stage #(
   parameter int IMEM_ADDR_W = 9
) (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   enable,
   input  logic                   stall,
   input  logic                   branch_taken,
   input  riscv_pkg::word_t       branch_target,
   input  logic [IMEM_ADDR_W-1:0] addr_ext,
   input  logic                   wen_ext,
   input  riscv_pkg::instr_t      wdata_ext,
   output riscv_pkg::instr_t      if_id_instr,
   output riscv_pkg::word_t       if_id_pc
);
   import riscv_pkg::*;

   word_t  pc;
   instr_t imem [2**IMEM_ADDR_W];
   instr_t fetched;

   // Word index from the byte address
   assign fetched = imem[pc[IMEM_ADDR_W+1:2]];

   // Program load port
   always_ff @(posedge clk) begin
      if (wen_ext) begin
         imem[addr_ext] <= wdata_ext;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         pc          <= '0;
         if_id_instr <= '0;
      end else if (enable) begin
         if (branch_taken) begin
            // Squash the slot fetched behind the beq
            pc          <= branch_target;
            if_id_instr <= '0;
         end else if (!stall) begin
            pc          <= pc + 64'd4;
            if_id_instr <= fetched;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (enable && !stall && !branch_taken) begin
         if_id_pc <= pc;
      end
   end

endmodule

`default_nettype wire

/* register_file.sv */
// Thirty-one general registers with x0 tied to zero and write-through reads
`default_nettype none

module register_file (
   input  logic                 clk,
   input  logic                 reset,
   input  riscv_pkg::reg_addr_t raddr_1,
   input  riscv_pkg::reg_addr_t raddr_2,
   output riscv_pkg::word_t     rdata_1,
   output riscv_pkg::word_t     rdata_2,
   input  logic                 wb_en,
   input  riscv_pkg::reg_addr_t wb_addr,
   input  riscv_pkg::word_t     wb_data
);
   import riscv_pkg::*;

   word_t regs [1:31];

   // Writeback value wins over the stored one
   function automatic word_t read_port(reg_addr_t raddr);
      if (raddr == '0) return '0;
      if (wb_en && wb_addr == raddr) return wb_data;
      return regs[raddr];
   endfunction

   always_comb rdata_1 = read_port(raddr_1);
   always_comb rdata_2 = read_port(raddr_2);

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wb_en && wb_addr != '0) begin
         regs[wb_addr] <= wb_data;
      end
   end

endmodule

`default_nettype wire

/* decode_stage.sv */
// Decode stage with control, immediates, hazard detection, early beq and decode/execute register
`default_nettype none

module decode_stage (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 enable,
   input  riscv_pkg::instr_t    if_id_instr,
   input  riscv_pkg::word_t     if_id_pc,
   output riscv_pkg::reg_addr_t raddr_1,
   output riscv_pkg::reg_addr_t raddr_2,
   input  riscv_pkg::word_t     rdata_1,
   input  riscv_pkg::word_t     rdata_2,
   output logic                 stall,
   output logic                 branch_taken,
   output riscv_pkg::word_t     branch_target,
   id_ex_if.producer            idex,
   ex_mem_if.peek               exmem
);
   import riscv_pkg::*;

   logic [6:0] opcode;
   reg_addr_t  rs1;
   reg_addr_t  rs2;
   reg_addr_t  ex_dst;
   logic       is_rtype, is_itype, is_load, is_store, is_branch;
   logic       use_rs1, use_rs2;
   logic       load_use, branch_hazard;
   word_t      imm_i, imm_s, imm_b, imm;
   word_t      cmp_1, cmp_2;

   function automatic word_t branch_operand(reg_addr_t rs, word_t rdata,
                                            reg_addr_t ex_rd, word_t ex_val);
      return (rs != '0 && rs == ex_rd) ? ex_val : rdata;
   endfunction

   assign opcode  = if_id_instr[6:0];
   assign rs1     = if_id_instr[RS1_LSB +: 5];
   assign rs2     = if_id_instr[RS2_LSB +: 5];
   assign raddr_1 = rs1;
   assign raddr_2 = rs2;

   assign is_rtype  = (opcode == OPC_RTYPE);
   assign is_itype  = (opcode == OPC_ITYPE);
   assign is_load   = (opcode == OPC_LOAD);
   assign is_store  = (opcode == OPC_STORE);
   assign is_branch = (opcode == OPC_BRANCH);
   assign use_rs1   = is_rtype | is_itype | is_load | is_store | is_branch;
   assign use_rs2   = is_rtype | is_store | is_branch;

   // Sign-extended immediates
   assign imm_i = {{52{if_id_instr[31]}}, if_id_instr[31:20]};
   assign imm_s = {{52{if_id_instr[31]}}, if_id_instr[31:25], if_id_instr[11:7]};
   assign imm_b = {{52{if_id_instr[31]}}, if_id_instr[7], if_id_instr[30:25],
                   if_id_instr[11:8], 1'b0};
   assign imm   = is_store ? imm_s : (is_branch ? imm_b : imm_i);

   // Load result not ready for the next instruction
   assign load_use = idex.mem_read && idex.rd != '0 &&
                     ((use_rs1 && idex.rd == rs1) || (use_rs2 && idex.rd == rs2));

   // beq waits for producers in execute and loads in memory
   assign branch_hazard = is_branch &&
      ((idex.reg_write && idex.rd != '0 && (idex.rd == rs1 || idex.rd == rs2)) ||
       (exmem.mem_read && exmem.rd != '0 && (exmem.rd == rs1 || exmem.rd == rs2)));

   assign stall = load_use || branch_hazard;

   assign ex_dst        = exmem.reg_write ? exmem.rd : '0;
   assign cmp_1         = branch_operand(rs1, rdata_1, ex_dst, exmem.alu_out);
   assign cmp_2         = branch_operand(rs2, rdata_2, ex_dst, exmem.alu_out);
   assign branch_taken  = is_branch && !branch_hazard && (cmp_1 == cmp_2);
   assign branch_target = if_id_pc + imm_b;

   // Control half of ID/EX, bubble on stall
   always_ff @(posedge clk) begin
      if (reset) begin
         idex.alu_src   <= 1'b0;
         idex.alu_op    <= ALUOP_ADD;
         idex.mem_read  <= 1'b0;
         idex.mem_write <= 1'b0;
         idex.mem_2_reg <= 1'b0;
         idex.reg_write <= 1'b0;
      end else if (enable) begin
         idex.alu_src   <= (is_itype | is_load | is_store) && !stall;
         idex.alu_op    <= is_rtype ? ALUOP_FUNCT : (is_branch ? ALUOP_SUB : ALUOP_ADD);
         idex.mem_read  <= is_load && !stall;
         idex.mem_write <= is_store && !stall;
         idex.mem_2_reg <= is_load && !stall;
         idex.reg_write <= (is_rtype | is_itype | is_load) && !stall;
      end
   end

   always_ff @(posedge clk) begin
      if (enable) begin
         idex.rs1     <= rs1;
         idex.rs2     <= rs2;
         idex.rd      <= if_id_instr[RD_LSB +: 5];
         idex.rdata_1 <= rdata_1;
         idex.rdata_2 <= rdata_2;
         idex.imm     <= imm;
         idex.funct3  <= if_id_instr[FUNCT3_LSB +: 3];
         idex.funct7  <= if_id_instr[FUNCT7_LSB +: 7];
      end
   end

endmodule

`default_nettype wire

/* execute_stage.sv */
// Execute stage with ALU control, operand forwarding, ALU and execute/memory register
`default_nettype none

module execute_stage (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 enable,
   id_ex_if.consumer            idex,
   ex_mem_if.producer           exmem,
   input  logic                 wb_en,
   input  riscv_pkg::reg_addr_t wb_addr,
   input  riscv_pkg::word_t     wb_data
);
   import riscv_pkg::*;

   alu_ctrl_t alu_ctrl;
   fwd_sel_t  fwd_a, fwd_b;
   reg_addr_t ex_dst, wb_dst;
   word_t     src_a, src_b, operand_b, alu_out;

   // Younger result first, x0 never forwards
   function automatic fwd_sel_t fwd_select(reg_addr_t rs, reg_addr_t ex_rd, reg_addr_t wb_rd);
      if (rs == '0) return FWD_NONE;
      if (rs == ex_rd) return FWD_EX_MEM;
      if (rs == wb_rd) return FWD_MEM_WB;
      return FWD_NONE;
   endfunction

   function automatic word_t fwd_value(fwd_sel_t sel, word_t reg_val,
                                       word_t ex_val, word_t wb_val);
      case (sel)
         FWD_EX_MEM: return ex_val;
         FWD_MEM_WB: return wb_val;
         default:    return reg_val;
      endcase
   endfunction

   always_comb begin
      case (idex.alu_op)
         ALUOP_SUB: alu_ctrl = ALU_SUB;
         ALUOP_FUNCT: begin
            case (idex.funct3)
               F3_ADD_SUB: alu_ctrl = (idex.funct7 == FUNCT7_SUB) ? ALU_SUB : ALU_ADD;
               F3_AND:     alu_ctrl = ALU_AND;
               F3_OR:      alu_ctrl = ALU_OR;
               default:    alu_ctrl = ALU_ADD;
            endcase
         end
         default: alu_ctrl = ALU_ADD;
      endcase
   end

   assign ex_dst    = exmem.reg_write ? exmem.rd : '0;
   assign wb_dst    = wb_en ? wb_addr : '0;
   assign fwd_a     = fwd_select(idex.rs1, ex_dst, wb_dst);
   assign fwd_b     = fwd_select(idex.rs2, ex_dst, wb_dst);
   assign src_a     = fwd_value(fwd_a, idex.rdata_1, exmem.alu_out, wb_data);
   assign src_b     = fwd_value(fwd_b, idex.rdata_2, exmem.alu_out, wb_data);
   assign operand_b = idex.alu_src ? idex.imm : src_b;

   always_comb begin
      case (alu_ctrl)
         ALU_SUB: alu_out = src_a - operand_b;
         ALU_AND: alu_out = src_a & operand_b;
         ALU_OR:  alu_out = src_a | operand_b;
         default: alu_out = src_a + operand_b;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         exmem.reg_write <= 1'b0;
         exmem.mem_read  <= 1'b0;
         exmem.mem_write <= 1'b0;
         exmem.mem_2_reg <= 1'b0;
      end else if (enable) begin
         exmem.reg_write <= idex.reg_write;
         exmem.mem_read  <= idex.mem_read;
         exmem.mem_write <= idex.mem_write;
         exmem.mem_2_reg <= idex.mem_2_reg;
      end
   end

   // Store data takes the forwarded rs2 value
   always_ff @(posedge clk) begin
      if (enable) begin
         exmem.alu_out    <= alu_out;
         exmem.store_data <= src_b;
         exmem.rd         <= idex.rd;
      end
   end

endmodule

`default_nettype wire

/* memory_stage.sv */
// Memory stage with external data port, memory/writeback register and writeback select
`default_nettype none

module memory_stage #(
   parameter int DMEM_ADDR_W = 10
) (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   enable,
   ex_mem_if.consumer             exmem,
   input  logic [DMEM_ADDR_W-1:0] addr_ext_2,
   input  logic                   wen_ext_2,
   input  logic                   ren_ext_2,
   input  riscv_pkg::word_t       wdata_ext_2,
   output riscv_pkg::word_t       rdata_ext_2,
   output logic                   wb_en,
   output riscv_pkg::reg_addr_t   wb_addr,
   output riscv_pkg::word_t       wb_data
);
   import riscv_pkg::*;

   word_t                  dmem [2**DMEM_ADDR_W];
   logic [DMEM_ADDR_W-1:0] dmem_idx;
   word_t                  load_data;
   logic                   memwb_mem_2_reg;
   word_t                  memwb_load;
   word_t                  memwb_alu;

   // Doubleword index from the byte address
   assign dmem_idx  = exmem.alu_out[DMEM_ADDR_W+2:3];
   assign load_data = dmem[dmem_idx];

   always_ff @(posedge clk) begin
      if (enable && exmem.mem_write) begin
         dmem[dmem_idx] <= exmem.store_data;
      end else if (wen_ext_2) begin
         dmem[addr_ext_2] <= wdata_ext_2;
      end
   end

   // External read holds until the next strobe
   always_ff @(posedge clk) begin
      if (ren_ext_2) begin
         rdata_ext_2 <= dmem[addr_ext_2];
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wb_en           <= 1'b0;
         memwb_mem_2_reg <= 1'b0;
      end else if (enable) begin
         wb_en           <= exmem.reg_write;
         memwb_mem_2_reg <= exmem.mem_2_reg;
      end
   end

   always_ff @(posedge clk) begin
      if (enable) begin
         wb_addr    <= exmem.rd;
         memwb_load <= load_data;
         memwb_alu  <= exmem.alu_out;
      end
   end

   assign wb_data = memwb_mem_2_reg ? memwb_load : memwb_alu;

endmodule

`default_nettype wire

/* cpu.sv */
// Top level of the five-stage RV64I subset pipeline
`default_nettype none

module cpu #(
   parameter int IMEM_ADDR_W = 9,
   parameter int DMEM_ADDR_W = 10
) (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   enable,
   input  logic [IMEM_ADDR_W-1:0] addr_ext,
   input  logic                   wen_ext,
   input  riscv_pkg::instr_t      wdata_ext,
   input  logic [DMEM_ADDR_W-1:0] addr_ext_2,
   input  logic                   wen_ext_2,
   input  logic                   ren_ext_2,
   input  riscv_pkg::word_t       wdata_ext_2,
   output riscv_pkg::word_t       rdata_ext_2
);
   import riscv_pkg::*;

   instr_t    if_id_instr;
   word_t     if_id_pc;
   logic      stall, branch_taken;
   word_t     branch_target;
   reg_addr_t raddr_1, raddr_2;
   word_t     rdata_1, rdata_2;
   // Writeback bus
   logic      wb_en;
   reg_addr_t wb_addr;
   word_t     wb_data;

   id_ex_if  idex ();
   ex_mem_if exmem ();

   fetch_stage #(.IMEM_ADDR_W(IMEM_ADDR_W)) u_fetch (
      .clk, .reset, .enable, .stall, .branch_taken, .branch_target,
      .addr_ext, .wen_ext, .wdata_ext, .if_id_instr, .if_id_pc
   );

   register_file u_regfile (
      .clk, .reset, .raddr_1, .raddr_2, .rdata_1, .rdata_2, .wb_en, .wb_addr, .wb_data
   );

   decode_stage u_decode (
      .clk, .reset, .enable, .if_id_instr, .if_id_pc, .raddr_1, .raddr_2,
      .rdata_1, .rdata_2, .stall, .branch_taken, .branch_target,
      .idex(idex.producer), .exmem(exmem.peek)
   );

   execute_stage u_execute (
      .clk, .reset, .enable, .idex(idex.consumer), .exmem(exmem.producer),
      .wb_en, .wb_addr, .wb_data
   );

   memory_stage #(.DMEM_ADDR_W(DMEM_ADDR_W)) u_memory (
      .clk, .reset, .enable, .exmem(exmem.consumer),
      .addr_ext_2, .wen_ext_2, .ren_ext_2, .wdata_ext_2, .rdata_ext_2,
      .wb_en, .wb_addr, .wb_data
   );

endmodule

`default_nettype wire

/* cpu_asserts.sv */
// Program counter and redirect checks, bound into the fetch stage
`default_nettype none

module cpu_asserts (
   input logic        clk,
   input logic        reset,
   input logic        enable,
   input logic        stall,
   input logic        branch_taken,
   input logic [63:0] pc
);
   timeunit 1ns;
   timeprecision 1ps;

   pc_after_reset: assert property (@(posedge clk) reset |=> pc == 64'd0)
      else $error("pc is not zero in the cycle after reset");

   // Frozen machine or decode stall keeps the fetch address
   pc_holds: assert property (@(posedge clk) disable iff (reset)
      (stall || !enable) |=> $stable(pc))
      else $error("pc moved while stalled or disabled");

   no_branch_in_stall: assert property (@(posedge clk) disable iff (reset)
      !(branch_taken && stall))
      else $error("branch_taken is high during a stall");

endmodule

bind fetch_stage cpu_asserts u_asserts (
   .clk, .reset, .enable, .stall, .branch_taken, .pc
);

`default_nettype wire

/* tb_cpu.sv */
// Testbench for the pipelined RV64I subset core, random programs checked against a serial model
`default_nettype none

module tb_cpu;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int IMEM_ADDR_W = 9;
   localparam int DMEM_ADDR_W = 10;
   localparam int N_PROGRAMS  = 8;
   localparam int N_RANDOM    = 24;
   localparam int PROG_LEN    = 39;
   localparam int N_WORDS     = 39;
   localparam logic [31:0] FINAL_BEQ = 32'h00000063;

   // Instruction kinds of the generator and the model
   localparam int K_ADD  = 0;
   localparam int K_SUB  = 1;
   localparam int K_AND  = 2;
   localparam int K_OR   = 3;
   localparam int K_ADDI = 4;
   localparam int K_LD   = 5;
   localparam int K_SD   = 6;
   localparam int K_BEQ  = 7;

   logic                   clk;
   logic                   reset;
   logic                   enable;
   logic [IMEM_ADDR_W-1:0] addr_ext;
   logic                   wen_ext;
   logic [31:0]            wdata_ext;
   logic [DMEM_ADDR_W-1:0] addr_ext_2;
   logic                   wen_ext_2;
   logic                   ren_ext_2;
   logic [63:0]            wdata_ext_2;
   logic [63:0]            rdata_ext_2;

   logic [31:0] lfsr_state;
   logic [31:0] prog [PROG_LEN];
   int          p_kind [PROG_LEN];
   logic [2:0]  p_rd [PROG_LEN];
   logic [2:0]  p_rs1 [PROG_LEN];
   logic [2:0]  p_rs2 [PROG_LEN];
   logic [63:0] p_imm [PROG_LEN];
   logic [63:0] model_regs [8];
   logic [63:0] model_mem [N_WORDS];
   int          checks;
   int          errors;
   int          timeouts;

   cpu #(.IMEM_ADDR_W(IMEM_ADDR_W), .DMEM_ADDR_W(DMEM_ADDR_W)) uut (
      .clk, .reset, .enable, .addr_ext, .wen_ext, .wdata_ext,
      .addr_ext_2, .wen_ext_2, .ren_ext_2, .wdata_ext_2, .rdata_ext_2
   );

   always #50 clk = ~clk;

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic int unsigned take_bits(input int n);
      int unsigned v;
      v = 0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_step(lfsr_state);
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   function automatic logic [2:0] pick_reg();
      return 3'(take_bits(3) % 7 + 1);
   endfunction

   task automatic put_instr(input int idx, input int kind, input logic [2:0] rd,
                            input logic [2:0] rs1, input logic [2:0] rs2,
                            input logic [12:0] imm);
      p_kind[idx] = kind;
      p_rd[idx]   = rd;
      p_rs1[idx]  = rs1;
      p_rs2[idx]  = rs2;
      p_imm[idx]  = {{51{imm[12]}}, imm};
      case (kind)
         K_ADD:  prog[idx] = {7'h00, 2'b0, rs2, 2'b0, rs1, 3'b000, 2'b0, rd, 7'b0110011};
         K_SUB:  prog[idx] = {7'h20, 2'b0, rs2, 2'b0, rs1, 3'b000, 2'b0, rd, 7'b0110011};
         K_AND:  prog[idx] = {7'h00, 2'b0, rs2, 2'b0, rs1, 3'b111, 2'b0, rd, 7'b0110011};
         K_OR:   prog[idx] = {7'h00, 2'b0, rs2, 2'b0, rs1, 3'b110, 2'b0, rd, 7'b0110011};
         K_ADDI: prog[idx] = {imm[11:0], 2'b0, rs1, 3'b000, 2'b0, rd, 7'b0010011};
         K_LD:   prog[idx] = {imm[11:0], 2'b0, rs1, 3'b011, 2'b0, rd, 7'b0000011};
         K_SD:   prog[idx] = {imm[11:5], 2'b0, rs2, 2'b0, rs1, 3'b011, imm[4:0], 7'b0100011};
         default: prog[idx] = {imm[12], imm[10:5], 2'b0, rs2, 2'b0, rs1, 3'b000,
                               imm[4:1], imm[11], 7'b1100011};
      endcase
   endtask

   task automatic build_program();
      int          kind;
      logic [2:0]  rd, rs1, rs2;
      logic [11:0] imm12;
      logic [4:0]  off;
      for (int i = 0; i < 7; i++) begin
         imm12 = 12'(take_bits(12));
         put_instr(i, K_ADDI, 3'(i + 1), 3'd0, 3'd0, {imm12[11], imm12});
      end
      for (int i = 7; i < 7 + N_RANDOM; i++) begin
         kind  = int'(take_bits(3));
         rd    = pick_reg();
         rs1   = pick_reg();
         rs2   = pick_reg();
         imm12 = 12'(take_bits(12));
         off   = 5'(take_bits(5));
         case (kind)
            K_LD, K_SD: put_instr(i, kind, rd, 3'd0, rs2, {5'b0, off, 3'b0});
            K_ADDI:     put_instr(i, kind, rd, rs1, 3'd0, {imm12[11], imm12});
            K_BEQ: begin
               // Equal sources half the time so that taken branches show up
               if (take_bits(1) == 1) rs2 = rs1;
               put_instr(i, kind, 3'd0, rs1, rs2, 13'd8);
            end
            default:    put_instr(i, kind, rd, rs1, rs2, 13'd0);
         endcase
      end
      for (int k = 0; k < 7; k++) begin
         put_instr(31 + k, K_SD, 3'd0, 3'd0, 3'(k + 1), 13'(256 + 8 * k));
      end
      put_instr(PROG_LEN - 1, K_BEQ, 3'd0, 3'd0, 3'd0, 13'd0);
   endtask

   // Serial ISA model up to the final self loop
   task automatic run_model();
      int          pc;
      logic [63:0] a, b;
      for (int r = 0; r < 8; r++) model_regs[r] = '0;
      for (int w = 0; w < N_WORDS; w++) model_mem[w] = '0;
      pc = 0;
      while (pc < PROG_LEN - 1) begin
         a = model_regs[p_rs1[pc]];
         b = model_regs[p_rs2[pc]];
         case (p_kind[pc])
            K_ADD:  model_regs[p_rd[pc]] = a + b;
            K_SUB:  model_regs[p_rd[pc]] = a - b;
            K_AND:  model_regs[p_rd[pc]] = a & b;
            K_OR:   model_regs[p_rd[pc]] = a | b;
            K_ADDI: model_regs[p_rd[pc]] = a + p_imm[pc];
            K_LD:   model_regs[p_rd[pc]] = model_mem[p_imm[pc][8:3]];
            K_SD:   model_mem[p_imm[pc][8:3]] = b;
            default: if (a == b) pc = pc + 1;
         endcase
         pc = pc + 1;
      end
   endtask

   // Program words plus two zero words behind it, data words cleared alongside
   task automatic load_program();
      for (int i = 0; i < PROG_LEN + 2; i++) begin
         @(negedge clk);
         wen_ext   = 1'b1;
         addr_ext  = i[IMEM_ADDR_W-1:0];
         if (i < PROG_LEN) wdata_ext = prog[i];
         else wdata_ext = '0;
         wen_ext_2   = (i < N_WORDS);
         addr_ext_2  = i[DMEM_ADDR_W-1:0];
         wdata_ext_2 = '0;
      end
      @(negedge clk);
      wen_ext   = 1'b0;
      wen_ext_2 = 1'b0;
   endtask

   task automatic wait_for_end(input int prog_no);
      int cycles;
      cycles = 0;
      while (uut.u_fetch.if_id_instr !== FINAL_BEQ && cycles < 3 * PROG_LEN + 20) begin
         @(negedge clk);
         cycles++;
      end
      if (uut.u_fetch.if_id_instr !== FINAL_BEQ) begin
         timeouts++;
         $display("timeout: program %0d never reached its final beq", prog_no);
      end
      // Let the last stores leave the pipeline
      repeat (4) @(negedge clk);
   endtask

   task automatic compare_data_memory(input int prog_no);
      for (int w = 0; w < N_WORDS; w++) begin
         @(negedge clk);
         ren_ext_2  = 1'b1;
         addr_ext_2 = w[DMEM_ADDR_W-1:0];
         @(negedge clk);
         ren_ext_2 = 1'b0;
         checks++;
         assert (rdata_ext_2 === model_mem[w]) else begin
            errors++;
            $display("error: rdata_ext_2 = %h, expected %h (word %0d, program %0d)",
                     rdata_ext_2, model_mem[w], w, prog_no);
         end
      end
   endtask

   task automatic ext_port_roundtrip();
      logic [63:0] value;
      int          addr;
      for (int k = 0; k < 8; k++) begin
         addr         = 64 + k * 97;
         value[63:32] = take_bits(32);
         value[31:0]  = take_bits(32);
         @(negedge clk);
         wen_ext_2   = 1'b1;
         addr_ext_2  = addr[DMEM_ADDR_W-1:0];
         wdata_ext_2 = value;
         @(negedge clk);
         wen_ext_2 = 1'b0;
         ren_ext_2 = 1'b1;
         @(negedge clk);
         ren_ext_2 = 1'b0;
         checks++;
         assert (rdata_ext_2 === value) else begin
            errors++;
            $display("error: rdata_ext_2 = %h, expected %h (word %0d)", rdata_ext_2, value, addr);
         end
      end
   endtask

   initial begin
      clk         = 1'b0;
      reset       = 1'b1;
      enable      = 1'b0;
      addr_ext    = '0;
      wen_ext     = 1'b0;
      wdata_ext   = '0;
      addr_ext_2  = '0;
      wen_ext_2   = 1'b0;
      ren_ext_2   = 1'b0;
      wdata_ext_2 = '0;
      lfsr_state  = 32'h8e38079d;
      checks      = 0;
      errors      = 0;
      timeouts    = 0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      ext_port_roundtrip();
      for (int p = 0; p < N_PROGRAMS && timeouts == 0; p++) begin
         build_program();
         run_model();
         @(negedge clk);
         reset = 1'b1;
         repeat (2) @(negedge clk);
         reset = 1'b0;
         load_program();
         enable = 1'b1;
         wait_for_end(p);
         enable = 1'b0;
         compare_data_memory(p);
      end
      $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* files.f */
riscv_pkg.sv
pipe_if.sv
fetch_stage.sv
register_file.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
cpu.sv
cpu_asserts.sv
tb_cpu.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_cpu
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG) || (echo "pass message missing from $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
